/* source/sys_arr_pkg.sv */
`default_nettype none

package sys_arr_pkg;

    // array dimension, sets grid size, queue depth and row width
    localparam int N = 4;

    // data word width, all arithmetic wraps at this width
    localparam int DW = 16;

    // row index width
    localparam int IDX_W = $clog2(N);

    // fill level width, has to reach N itself
    localparam int FILL_W = $clog2(N + 1);

    // one data word
    typedef logic [DW-1:0] word_t;

    // one matrix row, word 0 sits at the most significant end
    typedef word_t [0:N-1] row_t;

    // index of one row in a batch
    typedef logic [IDX_W-1:0] row_idx_t;

    // queue fill level or row count, 0..N
    typedef logic [FILL_W-1:0] fill_t;

endpackage

`default_nettype wire

/* source/sys_arr_ctrl_pkg.sv */
`default_nettype none

package sys_arr_ctrl_pkg;

    // engine phases
    typedef enum logic [1:0] {
        LOAD,
        COMPUTE,
        DRAIN
    } ctrl_state_t;

    // last input enters row N-1 at 2N-2,
    // last bottom sum of column N-1 lands at 3N-2
    localparam int COMPUTE_CYCLES = 3 * sys_arr_pkg::N - 1;

    // schedule counter width, holds up to 3N
    localparam int CNT_W = $clog2(3 * sys_arr_pkg::N + 1);

    // drain phase lasts one beat per result row
    localparam int DRAIN_CYCLES = sys_arr_pkg::N;

endpackage

`default_nettype wire

/* source/sysarr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sysarr_fifo
    import sys_arr_pkg::*;
(
    input  logic  clk,
    input  logic  nRST,
    input  logic  load,
    input  logic  shift,
    input  word_t load_value,
    output word_t out
);

    // ring buffer storage
    word_t    mem [N];
    row_idx_t wr_ptr;
    row_idx_t rd_ptr;
    fill_t    count;
    logic     push;
    logic     pop;

    // no append when full, no drop when empty
    assign push = load && (count != fill_t'(N));
    assign pop  = shift && (count != '0);

    // head, or zero once emptied
    assign out = (count == '0) ? '0 : mem[rd_ptr];

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fill_t'(push) - fill_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= load_value;
        end
    end

endmodule

`default_nettype wire

/* source/sysarr_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module sysarr_mac
    import sys_arr_pkg::*;
(
    input  logic  clk,
    input  logic  nRST,
    input  logic  weight_en,
    input  logic  step,
    input  word_t in_value,
    input  word_t in_accumulate,
    output word_t in_pass,
    output word_t out_accumulate
);

    // stationary weight of this cell
    word_t weight;

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            weight         <= '0;
            in_pass        <= '0;
            out_accumulate <= '0;
        end else if (step) begin
            // value moves one column right every step,
            // during a weight beat that is the new weight itself
            in_pass <= in_value;
            if (weight_en) begin
                weight <= in_value;
            end else begin
                // wraps at DW bits
                out_accumulate <= in_accumulate + weight * in_value;
            end
        end
    end

endmodule

`default_nettype wire

/* source/sysarr_out_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sysarr_out_fifo
    import sys_arr_pkg::*;
(
    input  logic  clk,
    input  logic  nRST,
    input  logic  capture,
    input  logic  pop,
    input  word_t column_sum,
    input  word_t partial,
    output word_t out
);

    // shift queue, head always in slot 0
    word_t q [N];
    fill_t fill;
    word_t result;
    fill_t wr_idx;
    logic  do_pop;
    logic  do_push;

    // partial sum added on the way in
    assign result  = column_sum + partial;
    assign do_pop  = pop && (fill != '0);
    assign do_push = capture && ((fill != fill_t'(N)) || do_pop);

    // slot after the last entry, one lower when popping
    assign wr_idx = do_pop ? fill - 1'b1 : fill;

    assign out = (fill == '0) ? '0 : q[0];

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            fill <= '0;
        end else begin
            fill <= fill + fill_t'(do_push) - fill_t'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            for (int i = 0; i < N - 1; i++) begin
                q[i] <= q[i + 1];
            end
        end
        if (do_push) begin
            q[wr_idx[FILL_W-2:0]] <= result;
        end
    end

endmodule

`default_nettype wire

/* source/sysarr_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module sysarr_control_unit
    import sys_arr_pkg::*;
    import sys_arr_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  logic        weight_en,
    input  logic        input_en,
    input  logic        partial_en,
    input  logic        compute_done,
    input  logic        drain_done,
    output ctrl_state_t state,
    output logic        mac_step,
    output logic        load_in,
    output logic        load_ps,
    output logic        fifo_has_space,
    output logic        drained,
    output logic        out_en,
    output row_idx_t    row_out
);

    // accepted rows of the current batch
    fill_t in_rows;
    fill_t ps_rows;
    fill_t in_rows_nxt;
    fill_t ps_rows_nxt;
    logic  batch_ready;

    // host may only load while idle
    assign fifo_has_space = (state == LOAD);

    // weight beats win over data beats,
    // a full kind ignores extra rows
    assign load_in = fifo_has_space && input_en && !weight_en
                     && (in_rows != fill_t'(N));
    assign load_ps = fifo_has_space && partial_en && !weight_en
                     && (ps_rows != fill_t'(N));

    assign in_rows_nxt = in_rows + fill_t'(load_in);
    assign ps_rows_nxt = ps_rows + fill_t'(load_ps);

    // both kinds complete, go compute next cycle
    assign batch_ready = (in_rows_nxt == fill_t'(N)) && (ps_rows_nxt == fill_t'(N));

    // grid steps every compute cycle and on each weight beat
    assign mac_step = (state == COMPUTE) || (fifo_has_space && weight_en);

    // one result row per drain cycle
    assign out_en = (state == DRAIN);

    // idle with nothing queued
    assign drained = fifo_has_space && (in_rows == '0) && (ps_rows == '0);

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            state   <= LOAD;
            in_rows <= '0;
            ps_rows <= '0;
            row_out <= '0;
        end else begin
            case (state)
                LOAD: begin
                    if (batch_ready) begin
                        // counts restart for the next batch
                        state   <= COMPUTE;
                        in_rows <= '0;
                        ps_rows <= '0;
                    end else begin
                        in_rows <= in_rows_nxt;
                        ps_rows <= ps_rows_nxt;
                    end
                end
                COMPUTE: begin
                    if (compute_done) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // index of the row shown this cycle
                    row_out <= row_out + 1'b1;
                    if (drain_done) begin
                        state   <= LOAD;
                        row_out <= '0;
                    end
                end
                default: begin
                    state <= LOAD;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/sysarr_schedule_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sysarr_schedule_timer
    import sys_arr_pkg::*;
    import sys_arr_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  ctrl_state_t state,
    output logic [N-1:0] in_shift,
    output logic [N-1:0] ps_shift,
    output logic [N-1:0] out_capture,
    output logic        compute_done,
    output logic        drain_done
);

    // cycles spent in the current phase
    logic [CNT_W-1:0] cnt;
    int               t;

    assign t = int'(cnt);

    // last cycle of each phase
    assign compute_done = (state == COMPUTE) && (t == COMPUTE_CYCLES - 1);
    assign drain_done   = (state == DRAIN) && (t == DRAIN_CYCLES - 1);

    // counter restarts whenever the phase is about to change
    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            cnt <= '0;
        end else if ((state == LOAD) || compute_done || drain_done) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // skewed windows, row k one cycle behind row k-1
    always_comb begin
        in_shift    = '0;
        ps_shift    = '0;
        out_capture = '0;
        if (state == COMPUTE) begin
            for (int i = 0; i < N; i++) begin
                // X rows enter row i over N cycles starting at i
                in_shift[i] = (t >= i) && (t < i + N);
                // column i bottom sums valid from i+N on
                ps_shift[i]    = (t >= i + N) && (t < i + 2 * N);
                out_capture[i] = (t >= i + N) && (t < i + 2 * N);
            end
        end
    end

endmodule

`default_nettype wire

/* source/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_array
    import sys_arr_pkg::*;
    import sys_arr_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  logic     weight_en,
    input  logic     input_en,
    input  logic     partial_en,
    input  row_idx_t row_in_en,
    input  row_idx_t row_ps_en,
    input  row_t     array_in,
    input  row_t     array_in_partials,
    output logic     fifo_has_space,
    output logic     drained,
    output logic     out_en,
    output row_idx_t row_out,
    output row_t     array_output
);

    ctrl_state_t  state;
    logic         mac_step;
    logic         load_in;
    logic         load_ps;
    logic         compute_done;
    logic         drain_done;
    logic         wt_beat;
    logic [N-1:0] in_shift;
    logic [N-1:0] ps_shift;
    logic [N-1:0] out_capture;

    // queue heads and grid wiring
    word_t in_head  [N];
    word_t ps_head  [N];
    word_t row_feed [N];
    word_t pass_q   [N][N];
    word_t acc_q    [N][N];
    word_t col_out  [N];

    // weight beat accepted this cycle
    assign wt_beat = weight_en && fifo_has_space;

    sysarr_control_unit i_ctrl (
        .clk(clk), .nRST(nRST),
        .weight_en(weight_en), .input_en(input_en), .partial_en(partial_en),
        .compute_done(compute_done), .drain_done(drain_done),
        .state(state), .mac_step(mac_step), .load_in(load_in), .load_ps(load_ps),
        .fifo_has_space(fifo_has_space), .drained(drained),
        .out_en(out_en), .row_out(row_out)
    );

    sysarr_schedule_timer i_timer (
        .clk(clk), .nRST(nRST), .state(state),
        .in_shift(in_shift), .ps_shift(ps_shift), .out_capture(out_capture),
        .compute_done(compute_done), .drain_done(drain_done)
    );

    for (genvar k = 0; k < N; k++) begin : g_row
        // input queue k holds column k of X
        sysarr_fifo i_in_fifo (
            .clk(clk), .nRST(nRST), .load(load_in), .shift(in_shift[k]),
            .load_value(array_in[k]), .out(in_head[k])
        );

        // weight word during a beat, else gated head so the skew sees zeros
        assign row_feed[k] = wt_beat     ? array_in[k] :
                             in_shift[k] ? in_head[k]  : '0;

        for (genvar c = 0; c < N; c++) begin : g_col
            word_t mac_in;
            word_t mac_acc;

            if (c == 0) begin : g_left
                assign mac_in = row_feed[k];
            end else begin : g_inner
                assign mac_in = pass_q[k][c-1];
            end

            // top row starts every column sum at zero
            if (k == 0) begin : g_top
                assign mac_acc = '0;
            end else begin : g_below
                assign mac_acc = acc_q[k-1][c];
            end

            sysarr_mac i_mac (
                .clk(clk), .nRST(nRST), .weight_en(wt_beat), .step(mac_step),
                .in_value(mac_in), .in_accumulate(mac_acc),
                .in_pass(pass_q[k][c]), .out_accumulate(acc_q[k][c])
            );
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_out
        // partial queue c holds column c of P
        sysarr_fifo i_ps_fifo (
            .clk(clk), .nRST(nRST), .load(load_ps), .shift(ps_shift[c]),
            .load_value(array_in_partials[c]), .out(ps_head[c])
        );

        // bottom row sum plus partial, popped together in drain
        sysarr_out_fifo i_out_fifo (
            .clk(clk), .nRST(nRST), .capture(out_capture[c]), .pop(out_en),
            .column_sum(acc_q[N-1][c]), .partial(ps_head[c]), .out(col_out[c])
        );

        assign array_output[c] = col_out[c];
    end

endmodule

`default_nettype wire

/* tb/systolic_array_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_array_checker
    import sys_arr_pkg::*;
(
    input logic     clk,
    input logic     nRST,
    input logic     load_in,
    input logic     load_ps,
    input row_idx_t row_in_en,
    input row_idx_t row_ps_en,
    input logic     fifo_has_space,
    input logic     drained,
    input logic     out_en,
    input row_idx_t row_out
);

    // next row index the host should send
    row_idx_t exp_in;
    row_idx_t exp_ps;

    // failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            exp_in <= '0;
            exp_ps <= '0;
        end else begin
            // wraps to 0 after row N-1, i.e. next batch
            if (load_in) begin
                exp_in <= exp_in + 1'b1;
            end
            if (load_ps) begin
                exp_ps <= exp_ps + 1'b1;
            end
        end
    end

    // results only while the engine is busy
    a_out_busy: assert property (@(posedge clk) disable iff (!nRST)
        out_en |-> !fifo_has_space)
        else begin
            fail_count++;
            $error("out_en while fifo_has_space is high");
        end

    a_drained_quiet: assert property (@(posedge clk) disable iff (!nRST)
        drained |-> !out_en)
        else begin
            fail_count++;
            $error("out_en while drained is high");
        end

    a_row_step: assert property (@(posedge clk) disable iff (!nRST)
        out_en && $past(out_en) |-> row_out == row_idx_t'($past(row_out) + 1'b1))
        else begin
            fail_count++;
            $error("row_out did not step by one between output beats");
        end

    a_in_order: assert property (@(posedge clk) disable iff (!nRST)
        load_in |-> row_in_en == exp_in)
        else begin
            fail_count++;
            $error("input row index out of order");
        end

    a_ps_order: assert property (@(posedge clk) disable iff (!nRST)
        load_ps |-> row_ps_en == exp_ps)
        else begin
            fail_count++;
            $error("partial row index out of order");
        end

endmodule

// accepted beats come from the control unit strobes
bind systolic_array systolic_array_checker i_checker (
    .clk(clk),
    .nRST(nRST),
    .load_in(load_in),
    .load_ps(load_ps),
    .row_in_en(row_in_en),
    .row_ps_en(row_ps_en),
    .fifo_has_space(fifo_has_space),
    .drained(drained),
    .out_en(out_en),
    .row_out(row_out)
);

`default_nettype wire

/* tb/tb_systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_systolic_array
    import sys_arr_pkg::*;
();

    // generous bound for any single wait
    localparam int WAIT_LIMIT = 20 * N;

    logic     clk;
    logic     nRST;
    logic     weight_en;
    logic     input_en;
    logic     partial_en;
    row_idx_t row_in_en;
    row_idx_t row_ps_en;
    row_t     array_in;
    row_t     array_in_partials;
    logic     fifo_has_space;
    logic     drained;
    logic     out_en;
    row_idx_t row_out;
    row_t     array_output;

    // matrices of the current batch
    word_t w_m [N][N];
    word_t x_m [N][N];
    word_t p_m [N][N];

    logic [31:0] rng = 32'd42408;
    int cyc = 0;
    int beats_seen = 0;
    int first_beat_cyc = 0;
    int last_load_cyc = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    systolic_array i_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // cycle number, advances on every rising edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic word_t rand_word();
        rng = xorshift(rng);
        return rng[15:0];
    endfunction

    // near_max keeps words within 255 of the top
    function automatic word_t make_word(input bit near_max);
        return near_max ? 16'hFFFF - (rand_word() & 16'h00FF) : rand_word();
    endfunction

    // expected row r: P + X*W, wrapped at 16 bits
    function automatic row_t ref_matmul(input int r);
        row_t  res;
        word_t acc;
        for (int c = 0; c < N; c++) begin
            acc = p_m[r][c];
            for (int k = 0; k < N; k++) begin
                acc = acc + x_m[r][k] * w_m[k][c];
            end
            res[c] = acc;
        end
        return res;
    endfunction

    // compare mismatches plus failed assertions
    function automatic int error_total();
        return err_count + i_dut.i_checker.fail_count;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic timeout_fail(input string what);
        err_count++;
        $display("timeout: %s never arrived within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic wait_space();
        int n;
        n = 0;
        while (!fifo_has_space && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!fifo_has_space) begin
            timeout_fail("fifo_has_space");
        end
    endtask

    task automatic wait_rows();
        int n;
        n = 0;
        while (beats_seen < N && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (beats_seen < N) begin
            timeout_fail("all output rows");
        end
    endtask

    task automatic fill_data(input bit near_max);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                x_m[r][c] = make_word(near_max);
                p_m[r][c] = make_word(near_max);
            end
        end
    endtask

    // weight beats go last column first
    task automatic load_weights(input bit near_max);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w_m[r][c] = make_word(near_max);
            end
        end
        for (int c = N - 1; c >= 0; c--) begin
            wait_space();
            weight_en = 1'b1;
            for (int k = 0; k < N; k++) begin
                array_in[k] = w_m[k][c];
            end
            @(negedge clk);
            weight_en = 1'b0;
        end
    endtask

    // kind 0 is an X row, kind 1 a P row
    task automatic load_row(input int kind, input int r);
        wait_space();
        if (kind == 0) begin
            input_en  = 1'b1;
            row_in_en = row_idx_t'(r);
            for (int k = 0; k < N; k++) begin
                array_in[k] = x_m[r][k];
            end
        end else begin
            partial_en = 1'b1;
            row_ps_en  = row_idx_t'(r);
            for (int c = 0; c < N; c++) begin
                array_in_partials[c] = p_m[r][c];
            end
        end
        last_load_cyc = cyc;
        @(negedge clk);
        input_en   = 1'b0;
        partial_en = 1'b0;
    endtask

    // mode 0 inputs first, 1 random interleave, 2 plus junk beats while busy
    task automatic run_batch(input int mode);
        int    ni;
        int    np;
        int    pick;
        word_t coin;
        ni = 0;
        np = 0;
        beats_seen = 0;
        while (ni < N || np < N) begin
            coin = rand_word();
            if (ni == N) begin
                pick = 1;
            end else if (np == N || mode != 1) begin
                pick = 0;
            end else begin
                pick = coin[0] ? 1 : 0;
            end
            if (pick == 0) begin
                load_row(0, ni);
                ni++;
            end else begin
                load_row(1, np);
                np++;
            end
        end
        if (mode == 2) begin
            // all three enables high, none of it may land
            for (int i = 0; i < 2 * N; i++) begin
                check_val("fifo_has_space", 32'(fifo_has_space), 32'd0);
                weight_en  = 1'b1;
                input_en   = 1'b1;
                partial_en = 1'b1;
                row_in_en  = row_idx_t'(i);
                row_ps_en  = row_idx_t'(i);
                for (int k = 0; k < N; k++) begin
                    array_in[k]          = rand_word();
                    array_in_partials[k] = rand_word();
                end
                @(negedge clk);
            end
            weight_en  = 1'b0;
            input_en   = 1'b0;
            partial_en = 1'b0;
        end
        wait_rows();
        wait_space();
        check_val("first out_en latency", 32'(first_beat_cyc - last_load_cyc), 32'(3 * N));
        check_val("drained", 32'(drained), 32'd1);
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = error_total() - errs_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
    endtask

    // result rows sampled before each rising edge
    initial begin
        row_t exp_row;
        forever begin
            @(posedge clk);
            if (out_en) begin
                if (beats_seen == 0) begin
                    first_beat_cyc = cyc;
                end
                if (beats_seen < N) begin
                    if (beats_seen != 0) begin
                        // result rows come back to back
                        check_val("out_en row cycle", 32'(cyc - first_beat_cyc),
                                  32'(beats_seen));
                    end
                    exp_row = ref_matmul(beats_seen);
                    check_val("row_out", 32'(row_out), 32'(beats_seen));
                    for (int c = 0; c < N; c++) begin
                        check_val($sformatf("array_output[%0d]", c),
                                  32'(array_output[c]), 32'(exp_row[c]));
                    end
                end else begin
                    err_count++;
                    $display("out_en stayed high beyond row %0d", N - 1);
                end
                beats_seen++;
            end
        end
    end

    initial begin
        int errs;
        nRST              = 1'b0;
        weight_en         = 1'b0;
        input_en          = 1'b0;
        partial_en        = 1'b0;
        row_in_en         = '0;
        row_ps_en         = '0;
        array_in          = '0;
        array_in_partials = '0;
        repeat (10) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);

        errs = error_total();
        check_val("out_en", 32'(out_en), 32'd0);
        check_val("fifo_has_space", 32'(fifo_has_space), 32'd1);
        check_val("drained", 32'(drained), 32'd1);
        end_test("reset state", errs);

        errs = error_total();
        load_weights(1'b0);
        fill_data(1'b0);
        run_batch(0);
        end_test("single batch", errs);

        // same weights, three fresh batches
        errs = error_total();
        for (int b = 0; b < 3; b++) begin
            fill_data(1'b0);
            run_batch(1);
        end
        end_test("interleave and weight reuse", errs);

        errs = error_total();
        fill_data(1'b0);
        run_batch(2);
        end_test("back-pressure", errs);

        errs = error_total();
        load_weights(1'b1);
        fill_data(1'b1);
        run_batch(1);
        end_test("weight reload and wrap", errs);

        errs = error_total();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errs);
        if (errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/sys_arr_pkg.sv
source/sys_arr_ctrl_pkg.sv
source/sysarr_fifo.sv
source/sysarr_mac.sv
source/sysarr_out_fifo.sv
source/sysarr_control_unit.sv
source/sysarr_schedule_timer.sv
source/systolic_array.sv
tb/systolic_array_checker.sv
tb/tb_systolic_array.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module tb_systolic_array -o sim_tb > build.log 2>&1 &&
    ./obj_dir/sim_tb > sim.log 2>&1 ||
    echo "build or simulation returned an error, see build.log and sim.log"
[ -f sim.log ] && cat sim.log
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log 2>/dev/null && echo "run_sim: pass" && exit 0 ||
    { echo "run_sim: fail"; exit 1; }
